// File: common/bp_pkg.sv
/*
 * Shared definitions for the branch-prediction front end
 * Address and pattern-history sizes, resolve outcome enum,
 * and the packed structs passed between fetch, resolve and the tables
 */

package bp_pkg;

    // Address width
    localparam int XLEN = 32;

    // Pattern-history table, also sets the global history length
    localparam int PHT_ENTRIES = 32;
    localparam int PHT_IDX_W = $clog2(PHT_ENTRIES);

    // Resolve classification
    typedef enum logic [1:0] {
        OUT_CORRECT,
        OUT_DIR_MISS,
        OUT_TGT_MISS
    } outcome_e;

    //////////////////////////////////////////////////////////////////////
    // Stage payloads
    //////////////////////////////////////////////////////////////////////

    // One fetched address with its prediction
    typedef struct packed {
        logic                 valid;
        logic [XLEN-1:0]      pc;
        logic                 pred_taken;
        logic [XLEN-1:0]      pred_target;
        logic [PHT_IDX_W-1:0] dirp_tag;
    } fetch_out_t;

    // One resolved control transfer from execute
    typedef struct packed {
        logic                 valid;
        logic                 is_cond;
        logic [XLEN-1:0]      pc;
        logic                 taken;
        logic [XLEN-1:0]      target;
        logic                 pred_taken;
        logic [XLEN-1:0]      pred_target;
        logic [PHT_IDX_W-1:0] dirp_tag;
    } ex_result_t;

    //////////////////////////////////////////////////////////////////////
    // Correction and training pulses
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        outcome_e        outcome;
    } redirect_t;

    typedef struct packed {
        logic                 valid;
        logic                 taken;
        logic [PHT_IDX_W-1:0] idx;
    } dirp_update_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] target;
    } btb_write_t;

endpackage

// File: hw/dirp/dirp.sv
/*
 * Gshare direction predictor
 * Global history register, table of 2-bit saturating counters,
 * combinational prediction and synchronous training
 */

`timescale 1ns/1ns

module dirp import bp_pkg::*; (
    input  logic                 clock,
    input  logic                 reset,

    // Training from resolve
    input  dirp_update_t         update,

    // Prediction for the current fetch PC
    input  logic                 is_branch,
    input  logic [XLEN-1:0]      pc,
    output logic                 branch_taken,
    output logic [PHT_IDX_W-1:0] dirp_tag
);

    // Global history, newest outcome in bit 0
    logic [PHT_IDX_W-1:0] history;

    // Counter table
    logic [1:0] pht [PHT_ENTRIES];

    logic [PHT_IDX_W-1:0] idx;
    logic [1:0]           upd_count;
    logic [1:0]           upd_next;

    //////////////////////////////////////////////////////////////////////
    // Prediction
    //////////////////////////////////////////////////////////////////////

    // History hashed with word-aligned PC bits
    assign idx = is_branch ? (history ^ pc[PHT_IDX_W+1:2]) : '0;

    // Upper counter bit is the taken direction
    assign branch_taken = is_branch & pht[idx][1];
    assign dirp_tag = idx;

    //////////////////////////////////////////////////////////////////////
    // Training
    //////////////////////////////////////////////////////////////////////

    assign upd_count = pht[update.idx];

    // Saturating step toward the resolved direction
    always_comb begin
        upd_next = upd_count;
        if (update.taken) begin
            if (upd_count != 2'b11) begin
                upd_next = upd_count + 2'b01;
            end
        end else begin
            if (upd_count != 2'b00) begin
                upd_next = upd_count - 2'b01;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            history <= '0;
            // Weakly not taken
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                pht[i] <= 2'b01;
            end
        end else if (update.valid) begin
            pht[update.idx] <= upd_next;
            history <= {history[PHT_IDX_W-2:0], update.taken};
        end
    end

endmodule

// File: hw/btb/btb.sv
/*
 * Direct-mapped branch target buffer
 * Valid, tag and target per entry, combinational lookup,
 * synchronous replace on write
 */

`timescale 1ns/1ns

module btb import bp_pkg::*; #(
    parameter int BTB_ENTRIES = 16
) (
    input  logic            clock,
    input  logic            reset,

    // Lookup
    input  logic [XLEN-1:0] pc,
    output logic            hit,
    output logic [XLEN-1:0] target,

    // Fill from resolve
    input  btb_write_t      write
);

    localparam int IDX_W = $clog2(BTB_ENTRIES);
    localparam int TAG_W = XLEN - IDX_W - 2;

    logic             entry_valid  [BTB_ENTRIES];
    logic [TAG_W-1:0] entry_tag    [BTB_ENTRIES];
    logic [XLEN-1:0]  entry_target [BTB_ENTRIES];

    logic [IDX_W-1:0] rd_idx;
    logic [TAG_W-1:0] rd_tag;
    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] wr_tag;

    //////////////////////////////////////////////////////////////////////
    // Address split
    //////////////////////////////////////////////////////////////////////

    // Index above the word offset, tag is everything above the index
    assign rd_idx = pc[IDX_W+1:2];
    assign rd_tag = pc[XLEN-1:IDX_W+2];
    assign wr_idx = write.pc[IDX_W+1:2];
    assign wr_tag = write.pc[XLEN-1:IDX_W+2];

    //////////////////////////////////////////////////////////////////////
    // Lookup
    //////////////////////////////////////////////////////////////////////

    assign hit = entry_valid[rd_idx] && (entry_tag[rd_idx] == rd_tag);
    assign target = entry_target[rd_idx];

    //////////////////////////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////////////////////////

    // All entries start invalid
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                entry_valid[i] <= 1'b0;
            end
        end else if (write.valid) begin
            entry_valid[wr_idx] <= 1'b1;
        end
    end

    // Tag and target replaced together with the valid bit
    always_ff @(posedge clock) begin
        if (write.valid) begin
            entry_tag[wr_idx] <= wr_tag;
            entry_target[wr_idx] <= write.target;
        end
    end

endmodule

// File: hw/bp_fetch_stage.sv
/*
 * Fetch stage
 * Program counter, next-PC choice from BTB and direction predictor,
 * redirect override and the registered fetch output
 */

`timescale 1ns/1ns

module bp_fetch_stage import bp_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = 32'h0000_1000
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 fetch_enable,
    input  redirect_t            redirect,

    // From the predictor tables
    input  logic                 btb_hit,
    input  logic [XLEN-1:0]      btb_target,
    input  logic                 dir_taken,
    input  logic [PHT_IDX_W-1:0] dir_tag,

    // Current PC, looked up in both tables
    output logic [XLEN-1:0]      pc,
    output fetch_out_t           fetch_out
);

    logic            pred_taken;
    logic [XLEN-1:0] seq_pc;
    logic [XLEN-1:0] pred_target;
    logic [XLEN-1:0] next_pc;

    //////////////////////////////////////////////////////////////////////
    // Prediction
    //////////////////////////////////////////////////////////////////////

    assign seq_pc = pc + XLEN'(4);

    // Taken only with a known target
    assign pred_taken = btb_hit & dir_taken;
    assign pred_target = pred_taken ? btb_target : seq_pc;

    // Redirect first, then the prediction, else hold
    always_comb begin
        if (redirect.valid) begin
            next_pc = redirect.pc;
        end else if (fetch_enable) begin
            next_pc = pred_target;
        end else begin
            next_pc = pc;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // PC and fetch output registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            fetch_out.valid <= 1'b0;
        end else begin
            // A redirect squashes the fetch of this cycle
            fetch_out.valid <= fetch_enable & ~redirect.valid;
            if (fetch_enable) begin
                fetch_out.pc <= pc;
                fetch_out.pred_taken <= pred_taken;
                fetch_out.pred_target <= pred_target;
                fetch_out.dirp_tag <= dir_tag;
            end
        end
    end

endmodule

// File: hw/bp_resolve_stage.sv
/*
 * Resolve stage
 * Registers execute results, compares them with the prediction,
 * and drives predictor training, BTB fill and fetch redirect
 */

`timescale 1ns/1ns

module bp_resolve_stage import bp_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  ex_result_t   ex_result,
    output redirect_t    redirect,
    output dirp_update_t dirp_update,
    output btb_write_t   btb_write
);

    ex_result_t      res_q;
    outcome_e        outcome;
    logic            dir_miss;
    logic            tgt_miss;
    logic [XLEN-1:0] fix_pc;

    //////////////////////////////////////////////////////////////////////
    // Result register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            res_q.valid <= 1'b0;
        end else begin
            res_q.valid <= ex_result.valid;
        end
    end

    // Payload follows the pulse
    always_ff @(posedge clock) begin
        if (ex_result.valid) begin
            res_q.is_cond <= ex_result.is_cond;
            res_q.pc <= ex_result.pc;
            res_q.taken <= ex_result.taken;
            res_q.target <= ex_result.target;
            res_q.pred_taken <= ex_result.pred_taken;
            res_q.pred_target <= ex_result.pred_target;
            res_q.dirp_tag <= ex_result.dirp_tag;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Classification
    //////////////////////////////////////////////////////////////////////

    assign dir_miss = res_q.taken != res_q.pred_taken;
    assign tgt_miss = res_q.taken & res_q.pred_taken & (res_q.pred_target != res_q.target);

    always_comb begin
        if (dir_miss) begin
            outcome = OUT_DIR_MISS;
        end else if (tgt_miss) begin
            outcome = OUT_TGT_MISS;
        end else begin
            outcome = OUT_CORRECT;
        end
    end

    // Either miss resumes at the real successor
    assign fix_pc = res_q.taken ? res_q.target : res_q.pc + XLEN'(4);

    //////////////////////////////////////////////////////////////////////
    // One-cycle pulses
    //////////////////////////////////////////////////////////////////////

    assign redirect.valid = res_q.valid && (outcome != OUT_CORRECT);
    assign redirect.pc = fix_pc;
    assign redirect.outcome = outcome;

    // Only conditional branches move the counters and the history
    assign dirp_update.valid = res_q.valid & res_q.is_cond;
    assign dirp_update.taken = res_q.taken;
    assign dirp_update.idx = res_q.dirp_tag;

    // Any taken transfer refreshes its target
    assign btb_write.valid = res_q.valid & res_q.taken;
    assign btb_write.pc = res_q.pc;
    assign btb_write.target = res_q.target;

endmodule

// File: hw/bp_top.sv
/*
 * Branch-prediction front end top level
 * Fetch and resolve stages around the BTB and gshare predictor
 */

`timescale 1ns/1ns

module bp_top import bp_pkg::*; #(
    parameter int              BTB_ENTRIES = 16,
    parameter logic [XLEN-1:0] RESET_PC = 32'h0000_1000
) (
    input  logic       clock,
    input  logic       reset,
    input  logic       fetch_enable,
    input  ex_result_t ex_result,
    output fetch_out_t fetch_out,
    output redirect_t  redirect
);

    logic [XLEN-1:0]      fetch_pc;
    logic                 btb_hit;
    logic [XLEN-1:0]      btb_target;
    logic                 dir_taken;
    logic [PHT_IDX_W-1:0] dir_tag;
    dirp_update_t         dirp_update;
    btb_write_t           btb_write;

    bp_fetch_stage #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .clock(clock),
        .reset(reset),
        .fetch_enable(fetch_enable),
        .redirect(redirect),
        .btb_hit(btb_hit),
        .btb_target(btb_target),
        .dir_taken(dir_taken),
        .dir_tag(dir_tag),
        .pc(fetch_pc),
        .fetch_out(fetch_out)
    );

    btb #(
        .BTB_ENTRIES(BTB_ENTRIES)
    ) u_btb (
        .clock(clock),
        .reset(reset),
        .pc(fetch_pc),
        .hit(btb_hit),
        .target(btb_target),
        .write(btb_write)
    );

    // Predict only where the BTB knows a branch
    dirp u_dirp (
        .clock(clock),
        .reset(reset),
        .update(dirp_update),
        .is_branch(btb_hit),
        .pc(fetch_pc),
        .branch_taken(dir_taken),
        .dirp_tag(dir_tag)
    );

    bp_resolve_stage u_resolve (
        .clock(clock),
        .reset(reset),
        .ex_result(ex_result),
        .redirect(redirect),
        .dirp_update(dirp_update),
        .btb_write(btb_write)
    );

endmodule

// File: test/bp_tb.sv
/*
 * Testbench for the branch-prediction front end
 * Clock, reset, watchdog, reference model of the counters, history and BTB,
 * and the directed tests
 */

`timescale 1ns/1ns

module bp_tb import bp_pkg::*; ();

    localparam int              CLK_PERIOD = 20;
    localparam int              DRIVE_DELAY = 2;
    localparam int              BTB_ENTRIES = 16;
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_1000;
    localparam int              NUM_TESTS = 6;
    localparam int              WATCHDOG_CYCLES = 200 * NUM_TESTS + 500;
    localparam logic [31:0]     SEED = 32'h870c5d3d;

    // Jump used to steer fetch, BTB index 15 kept free of test branches
    localparam logic [XLEN-1:0] JUMP_PC = 32'h0000_803c;
    localparam logic [XLEN-1:0] BR_A = 32'h0000_200c;
    localparam logic [XLEN-1:0] TGT_A = 32'h0000_2400;
    localparam logic [XLEN-1:0] BR_B = 32'h0000_3018;
    localparam logic [XLEN-1:0] TGT_B = 32'h0000_3400;
    localparam logic [XLEN-1:0] BR_C = 32'h0000_4070;
    localparam logic [XLEN-1:0] TGT_C1 = 32'h0000_4800;
    localparam logic [XLEN-1:0] TGT_C2 = 32'h0000_4900;

    logic       clock;
    logic       reset;
    logic       fetch_enable;
    ex_result_t ex_result;
    fetch_out_t fetch_out;
    redirect_t  redirect;

    int errors;
    int tests_run;
    int tests_failed;

    // Reference model state
    logic [1:0]           pht_m [PHT_ENTRIES];
    logic [PHT_IDX_W-1:0] hist_m;
    logic                 btb_valid_m [BTB_ENTRIES];
    logic [XLEN-1:0]      btb_pc_m [BTB_ENTRIES];
    logic [XLEN-1:0]      btb_tgt_m [BTB_ENTRIES];
    logic [XLEN-1:0]      exp_pc;

    // Last responses seen by the helpers
    redirect_t  seen_redirect;
    fetch_out_t seen_fetch;

    bp_top #(
        .BTB_ENTRIES(BTB_ENTRIES),
        .RESET_PC(RESET_PC)
    ) UUT (
        .clock(clock),
        .reset(reset),
        .fetch_enable(fetch_enable),
        .ex_result(ex_result),
        .fetch_out(fetch_out),
        .redirect(redirect)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic btb_lookup_hit(input logic [XLEN-1:0] pc);
        int i;
        i = (pc >> 2) % BTB_ENTRIES;
        return btb_valid_m[i] && (btb_pc_m[i][XLEN-1:2] == pc[XLEN-1:2]);
    endfunction

    function automatic logic [PHT_IDX_W-1:0] gshare_index(input logic [XLEN-1:0] pc);
        return btb_lookup_hit(pc) ? (hist_m ^ pc[PHT_IDX_W+1:2]) : '0;
    endfunction

    function automatic logic predict_taken(input logic [XLEN-1:0] pc);
        return btb_lookup_hit(pc) && (pht_m[gshare_index(pc)] >= 2'd2);
    endfunction

    function automatic logic [XLEN-1:0] predict_target(input logic [XLEN-1:0] pc);
        int i;
        i = (pc >> 2) % BTB_ENTRIES;
        return predict_taken(pc) ? btb_tgt_m[i] : pc + 32'd4;
    endfunction

    task automatic clear_model();
        for (int i = 0; i < PHT_ENTRIES; i++) begin
            pht_m[i] = 2'd1;
        end
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            btb_valid_m[i] = 1'b0;
        end
        hist_m = '0;
        exp_pc = RESET_PC;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    task automatic tick();
        @(posedge clock);
        #DRIVE_DELAY;
    endtask

    task automatic expect_equal(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        assert (actual === expected) else begin
            $display("[ERROR] %s: got %h, expected %h", name, actual, expected);
            errors++;
        end
    endtask

    // Fetch output against the model, then follow the predicted path
    task automatic compare_fetch();
        expect_equal("fetch_out.pc", fetch_out.pc, exp_pc);
        expect_equal("fetch_out.pred_taken", 32'(fetch_out.pred_taken),
                     32'(predict_taken(exp_pc)));
        expect_equal("fetch_out.pred_target", fetch_out.pred_target, predict_target(exp_pc));
        expect_equal("fetch_out.dirp_tag", 32'(fetch_out.dirp_tag), 32'(gshare_index(exp_pc)));
        seen_fetch = fetch_out;
        exp_pc = predict_target(exp_pc);
    endtask

    task automatic fetch_and_check();
        int waited;
        waited = 0;
        fetch_enable = 1'b1;
        tick();
        while (!fetch_out.valid && waited < 20) begin
            tick();
            waited++;
        end
        fetch_enable = 1'b0;
        assert (fetch_out.valid) else begin
            $display("Fetch output never became valid within 20 cycles");
            errors++;
        end
        if (fetch_out.valid) begin
            compare_fetch();
        end
    endtask

    // One result pulse, redirect checked by the resolve rule, model trained
    task automatic issue_result(input logic is_cond, input logic [XLEN-1:0] pc,
                                input logic taken, input logic [XLEN-1:0] target,
                                input logic pred_taken, input logic [XLEN-1:0] pred_target,
                                input logic [PHT_IDX_W-1:0] tag);
        outcome_e        exp_out;
        logic [XLEN-1:0] exp_fix;
        int              i;
        if (taken != pred_taken) begin
            exp_out = OUT_DIR_MISS;
            exp_fix = taken ? target : pc + 32'd4;
        end else if (taken && pred_target != target) begin
            exp_out = OUT_TGT_MISS;
            exp_fix = target;
        end else begin
            exp_out = OUT_CORRECT;
            exp_fix = '0;
        end
        ex_result = '{valid: 1'b1, is_cond: is_cond, pc: pc, taken: taken, target: target,
                      pred_taken: pred_taken, pred_target: pred_target, dirp_tag: tag};
        tick();
        ex_result.valid = 1'b0;
        seen_redirect = redirect;
        expect_equal("redirect.valid", 32'(redirect.valid), 32'(exp_out != OUT_CORRECT));
        if (exp_out != OUT_CORRECT) begin
            expect_equal("redirect.pc", redirect.pc, exp_fix);
            expect_equal("redirect.outcome", 32'(redirect.outcome), 32'(exp_out));
            exp_pc = exp_fix;
        end
        if (is_cond) begin
            if (taken && pht_m[tag] != 2'd3) begin
                pht_m[tag] = pht_m[tag] + 2'd1;
            end else if (!taken && pht_m[tag] != 2'd0) begin
                pht_m[tag] = pht_m[tag] - 2'd1;
            end
            hist_m = {hist_m[PHT_IDX_W-2:0], taken};
        end
        if (taken) begin
            i = (pc >> 2) % BTB_ENTRIES;
            btb_valid_m[i] = 1'b1;
            btb_pc_m[i] = pc;
            btb_tgt_m[i] = target;
        end
        tick();
    endtask

    // Unpredicted jump whose redirect places the PC at addr
    task automatic steer_fetch(input logic [XLEN-1:0] addr);
        issue_result(1'b0, JUMP_PC, 1'b1, addr, 1'b0, JUMP_PC + 32'd4, '0);
    endtask

    // Self-looping jump placed so that its fetch reads the counter at idx
    task automatic probe_counter(input logic [PHT_IDX_W-1:0] idx, input logic exp_taken);
        logic [XLEN-1:0] probe_pc;
        probe_pc = 32'h0000_7000 | (XLEN'(hist_m ^ idx) << 2);
        issue_result(1'b0, probe_pc, 1'b1, probe_pc, 1'b0, probe_pc + 32'd4, '0);
        fetch_and_check();
        expect_equal("fetch_out.dirp_tag", 32'(seen_fetch.dirp_tag), 32'(idx));
        expect_equal("fetch_out.pred_taken", 32'(seen_fetch.pred_taken), 32'(exp_taken));
    endtask

    task automatic report_result(input string name, input int start_errors);
        tests_run++;
        if (errors == start_errors) begin
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: %0d error(s)", tests_run, name, errors - start_errors);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic sequential_fetch();
        int start_errors;
        start_errors = errors;
        fetch_enable = 1'b1;
        repeat (8) begin
            tick();
            expect_equal("fetch_out.valid", 32'(fetch_out.valid), 32'd1);
            compare_fetch();
        end
        fetch_enable = 1'b0;
        report_result("sequential fetch", start_errors);
    endtask

    task automatic stall_and_resume();
        int start_errors;
        start_errors = errors;
        repeat (5) begin
            tick();
            expect_equal("fetch_out.valid", 32'(fetch_out.valid), 32'd0);
        end
        fetch_and_check();
        report_result("stall and resume", start_errors);
    endtask

    task automatic taken_branch_training();
        int   start_errors;
        logic expect_taken;
        start_errors = errors;
        issue_result(1'b1, BR_A, 1'b1, TGT_A, predict_taken(BR_A), predict_target(BR_A),
                     gshare_index(BR_A));
        expect_equal("redirect.outcome", 32'(seen_redirect.outcome), 32'(OUT_DIR_MISS));
        expect_equal("redirect.pc", seen_redirect.pc, TGT_A);
        fetch_and_check();
        issue_result(1'b1, BR_A, 1'b1, TGT_A, predict_taken(BR_A), predict_target(BR_A),
                     gshare_index(BR_A));
        steer_fetch(BR_A);
        expect_taken = predict_taken(BR_A);
        fetch_and_check();
        if (expect_taken) begin
            expect_equal("fetch_out.pred_taken", 32'(seen_fetch.pred_taken), 32'd1);
            expect_equal("fetch_out.pred_target", seen_fetch.pred_target, TGT_A);
            fetch_and_check();
            expect_equal("fetch_out.pc", seen_fetch.pc, TGT_A);
        end
        report_result("taken-branch training", start_errors);
    endtask

    task automatic hysteresis();
        int                   start_errors;
        int                   n;
        logic [PHT_IDX_W-1:0] idx;
        start_errors = errors;
        n = 0;
        // History fills with ones, so the index settles and saturates
        while (!(btb_lookup_hit(BR_B) && pht_m[gshare_index(BR_B)] == 2'd3) && n < 12) begin
            issue_result(1'b1, BR_B, 1'b1, TGT_B, predict_taken(BR_B), predict_target(BR_B),
                         gshare_index(BR_B));
            n++;
        end
        idx = gshare_index(BR_B);
        steer_fetch(BR_B);
        fetch_and_check();
        expect_equal("fetch_out.pred_taken", 32'(seen_fetch.pred_taken), 32'd1);
        issue_result(1'b1, BR_B, 1'b0, TGT_B, seen_fetch.pred_taken, seen_fetch.pred_target,
                     seen_fetch.dirp_tag);
        expect_equal("redirect.outcome", 32'(seen_redirect.outcome), 32'(OUT_DIR_MISS));
        expect_equal("redirect.pc", seen_redirect.pc, BR_B + 32'd4);
        // Strongly taken drops only to weakly taken
        probe_counter(idx, 1'b1);
        issue_result(1'b1, BR_B, 1'b0, TGT_B, pht_m[idx][1], TGT_B, idx);
        expect_equal("redirect.outcome", 32'(seen_redirect.outcome), 32'(OUT_DIR_MISS));
        probe_counter(idx, 1'b0);
        steer_fetch(BR_B);
        fetch_and_check();
        report_result("hysteresis", start_errors);
    endtask

    task automatic target_miss();
        int   start_errors;
        logic expect_taken;
        start_errors = errors;
        issue_result(1'b0, BR_C, 1'b1, TGT_C1, 1'b0, BR_C + 32'd4, gshare_index(BR_C));
        issue_result(1'b0, BR_C, 1'b1, TGT_C2, 1'b1, TGT_C1, gshare_index(BR_C));
        expect_equal("redirect.outcome", 32'(seen_redirect.outcome), 32'(OUT_TGT_MISS));
        expect_equal("redirect.pc", seen_redirect.pc, TGT_C2);
        steer_fetch(BR_C);
        expect_taken = predict_taken(BR_C);
        fetch_and_check();
        if (expect_taken) begin
            expect_equal("fetch_out.pred_target", seen_fetch.pred_target, TGT_C2);
        end
        report_result("target miss", start_errors);
    endtask

    task automatic history_tags();
        int              start_errors;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] target;
        logic            taken;
        start_errors = errors;
        for (int k = 0; k < 16; k++) begin
            pc = 32'h0000_5000 | ($urandom() & 32'h0000_03fc);
            target = 32'h0000_6000 | ($urandom() & 32'h0000_03fc);
            // Mostly taken so that the BTB fills
            taken = ($urandom() % 4) != 0;
            issue_result(1'b1, pc, taken, target, predict_taken(pc), predict_target(pc),
                         gshare_index(pc));
            steer_fetch(pc);
            fetch_and_check();
        end
        report_result("history and dirp_tag", start_errors);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        fetch_enable = 1'b0;
        ex_result = '0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        void'($urandom(SEED));
        clear_model();
        repeat (5) @(posedge clock);
        #DRIVE_DELAY;
        reset = 1'b0;

        sequential_fetch();
        stall_and_resume();
        taken_branch_training();
        hysteresis();
        target_miss();
        history_tags();

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: sim.f
common/bp_pkg.sv
hw/dirp/dirp.sv
hw/btb/btb.sv
hw/bp_fetch_stage.sv
hw/bp_resolve_stage.sv
hw/bp_top.sv
test/bp_tb.sv

// File: Makefile
# Verilator build and run of the branch-prediction front end

VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert --timescale 1ns/1ns
LINT_FLAGS ?= --lint-only --timing --assert --timescale 1ns/1ns
TOP        ?= bp_tb
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   := *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The log search decides the result
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
